//--- design/nf_cpu_pkg.sv
// shared widths, word and register index types, ALU operation codes
// RV32I opcode, funct3 and funct7 constants for the integer subset
`default_nettype none

package nf_cpu_pkg;

    parameter int XLEN = 32;                        // data path width

    typedef logic [XLEN-1 : 0] word_t;              // data, address or instruction word
    typedef logic [4 : 0]      reg_addr_t;          // register file index

    // ALU operation selected in decode
    typedef enum logic [2 : 0] {
        ALU_ADD    = 3'd0,                          // add, also store address
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLL    = 3'd5,                          // shift left logical
        ALU_SRL    = 3'd6,                          // shift right logical
        ALU_PASS_B = 3'd7                           // operand b straight through, for lui
    } alu_op_t;

    // major opcodes
    parameter logic [6 : 0] OPC_OP     = 7'b0110011;    // register-register ops
    parameter logic [6 : 0] OPC_OP_IMM = 7'b0010011;    // register-immediate ops
    parameter logic [6 : 0] OPC_LUI    = 7'b0110111;    // load upper immediate
    parameter logic [6 : 0] OPC_STORE  = 7'b0100011;    // stores

    // funct3 field values
    parameter logic [2 : 0] F3_ADD_SUB = 3'b000;
    parameter logic [2 : 0] F3_SLL     = 3'b001;
    parameter logic [2 : 0] F3_SW      = 3'b010;        // word store
    parameter logic [2 : 0] F3_XOR     = 3'b100;
    parameter logic [2 : 0] F3_SRL     = 3'b101;
    parameter logic [2 : 0] F3_OR      = 3'b110;
    parameter logic [2 : 0] F3_AND     = 3'b111;

    parameter logic [6 : 0] F7_SUB     = 7'b0100000;    // funct7 that turns add into sub

endpackage : nf_cpu_pkg

`default_nettype wire

//--- design/nf_stage_ifs.sv
// decode-to-execute and execute-to-memory pipeline bundles
`timescale 1ns/1ps
`default_nettype none

interface nf_decode_exec_if;

    logic                   valid;      // instruction present in execute
    nf_cpu_pkg::reg_addr_t  ra1;        // source indices, kept for forwarding
    nf_cpu_pkg::reg_addr_t  ra2;
    nf_cpu_pkg::word_t      rd1;        // register values read in decode
    nf_cpu_pkg::word_t      rd2;
    nf_cpu_pkg::word_t      imm;        // extended immediate
    nf_cpu_pkg::alu_op_t    alu_op;
    logic                   srcb_imm;   // immediate as operand b
    nf_cpu_pkg::reg_addr_t  wa;         // destination index
    logic                   we_rf;      // writes the register file
    logic                   is_store;

    modport decode (output valid, ra1, ra2, rd1, rd2, imm, alu_op, srcb_imm, wa, we_rf, is_store);
    modport exec   (input  valid, ra1, ra2, rd1, rd2, imm, alu_op, srcb_imm, wa, we_rf, is_store);

endinterface : nf_decode_exec_if

interface nf_exec_mem_if;

    logic                   valid;      // instruction present in memory/writeback
    nf_cpu_pkg::word_t      result;     // alu value or store address
    nf_cpu_pkg::word_t      store_data; // forwarded rs2
    nf_cpu_pkg::reg_addr_t  wa;
    logic                   we_rf;
    logic                   is_store;

    modport exec (output valid, result, store_data, wa, we_rf, is_store);
    modport mem  (input  valid, result, store_data, wa, we_rf, is_store);

endinterface : nf_exec_mem_if

`default_nettype wire

//--- design/nf_fetch_unit.sv
// program counter, instruction request and fetch-to-decode register
`timescale 1ns/1ps
`default_nettype none

module nf_fetch_unit #(
    parameter nf_cpu_pkg::word_t RESET_PC = '0          // first fetch address
)(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                stall_i,                // store waiting for ack
    output nf_cpu_pkg::word_t   imem_addr_o,
    input  nf_cpu_pkg::word_t   imem_rd_i,
    output logic                imem_req_o,
    input  logic                imem_ack_i,
    output nf_cpu_pkg::word_t   instr_o,                // to decode
    output logic                instr_valid_o
);

    nf_cpu_pkg::word_t  pc_q;                           // address of the next fetch
    logic               run_q;                          // set one edge after reset release
    logic               fetch_ok;                       // req and ack meet at this edge

    assign imem_req_o  = run_q & ~stall_i;              // no request while frozen
    assign imem_addr_o = pc_q;
    assign fetch_ok    = imem_req_o & imem_ack_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q         <= 1'b0;
            pc_q          <= RESET_PC;
            instr_valid_o <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (!stall_i) begin                         // hold pc and valid while stalled
                instr_valid_o <= fetch_ok;              // missing ack gives a bubble
                if (fetch_ok)
                    pc_q <= pc_q + 32'd4;
            end
        end
    end

    // instruction word, only meaningful with instr_valid_o
    always_ff @(posedge clk) begin
        if (fetch_ok)
            instr_o <= imem_rd_i;
    end

endmodule : nf_fetch_unit

`default_nettype wire

//--- design/nf_decode_unit.sv
// instruction field decode, immediate extension, decode-to-execute register
`timescale 1ns/1ps
`default_nettype none

module nf_decode_unit (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    stall_i,
    input  nf_cpu_pkg::word_t       instr_i,
    input  logic                    instr_valid_i,
    output nf_cpu_pkg::reg_addr_t   ra1_o,              // to register file
    output nf_cpu_pkg::reg_addr_t   ra2_o,
    input  nf_cpu_pkg::word_t       rd1_i,              // write-through values
    input  nf_cpu_pkg::word_t       rd2_i,
    nf_decode_exec_if.decode        de
);

    logic [6 : 0]           opcode;
    logic [2 : 0]           funct3;
    logic [6 : 0]           funct7;
    logic                   known;                      // opcode and funct3 supported
    nf_cpu_pkg::word_t      imm;
    nf_cpu_pkg::alu_op_t    alu_op;
    logic                   srcb_imm;
    logic                   we_rf;
    logic                   is_store;

    assign opcode = instr_i[6 : 0];
    assign funct3 = instr_i[14 : 12];
    assign funct7 = instr_i[31 : 25];
    assign ra1_o  = instr_i[19 : 15];
    assign ra2_o  = instr_i[24 : 20];

    always_comb begin
        known    = 1'b1;
        imm      = {{20{instr_i[31]}}, instr_i[31 : 20]};                   // i-type by default
        alu_op   = nf_cpu_pkg::ALU_ADD;
        srcb_imm = 1'b1;
        we_rf    = 1'b1;
        is_store = 1'b0;
        case (opcode)
            nf_cpu_pkg::OPC_OP: begin
                srcb_imm = 1'b0;
                case (funct3)
                    nf_cpu_pkg::F3_ADD_SUB: alu_op = (funct7 == nf_cpu_pkg::F7_SUB) ?
                                                     nf_cpu_pkg::ALU_SUB : nf_cpu_pkg::ALU_ADD;
                    nf_cpu_pkg::F3_SLL:     alu_op = nf_cpu_pkg::ALU_SLL;
                    nf_cpu_pkg::F3_SRL:     alu_op = nf_cpu_pkg::ALU_SRL;
                    nf_cpu_pkg::F3_XOR:     alu_op = nf_cpu_pkg::ALU_XOR;
                    nf_cpu_pkg::F3_OR:      alu_op = nf_cpu_pkg::ALU_OR;
                    nf_cpu_pkg::F3_AND:     alu_op = nf_cpu_pkg::ALU_AND;
                    default:                known  = 1'b0;                  // slt family not kept
                endcase
            end
            nf_cpu_pkg::OPC_OP_IMM: begin
                case (funct3)
                    nf_cpu_pkg::F3_ADD_SUB: alu_op = nf_cpu_pkg::ALU_ADD;   // addi
                    nf_cpu_pkg::F3_XOR:     alu_op = nf_cpu_pkg::ALU_XOR;
                    nf_cpu_pkg::F3_OR:      alu_op = nf_cpu_pkg::ALU_OR;
                    nf_cpu_pkg::F3_AND:     alu_op = nf_cpu_pkg::ALU_AND;
                    default:                known  = 1'b0;
                endcase
            end
            nf_cpu_pkg::OPC_LUI: begin
                imm    = {instr_i[31 : 12], 12'h000};                       // u-type
                alu_op = nf_cpu_pkg::ALU_PASS_B;
            end
            nf_cpu_pkg::OPC_STORE: begin
                imm      = {{20{instr_i[31]}}, instr_i[31 : 25], instr_i[11 : 7]};  // s-type
                we_rf    = 1'b0;
                is_store = 1'b1;
                known    = (funct3 == nf_cpu_pkg::F3_SW);                   // word stores only
            end
            default: known = 1'b0;                                          // unknown is a bubble
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            de.valid <= 1'b0;
        else if (!stall_i)
            de.valid <= instr_valid_i & known;
    end

    // operands and control for execute
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            de.ra1      <= ra1_o;
            de.ra2      <= ra2_o;
            de.rd1      <= rd1_i;
            de.rd2      <= rd2_i;
            de.imm      <= imm;
            de.alu_op   <= alu_op;
            de.srcb_imm <= srcb_imm;
            de.wa       <= instr_i[11 : 7];
            de.we_rf    <= we_rf;
            de.is_store <= is_store;
        end
    end

endmodule : nf_decode_unit

`default_nettype wire

//--- design/nf_reg_file.sv
// two-read, one-write register file, x0 reads zero, write-through reads
`timescale 1ns/1ps
`default_nettype none

module nf_reg_file (
    input  logic                    clk,
    input  nf_cpu_pkg::reg_addr_t   ra1_i,
    input  nf_cpu_pkg::reg_addr_t   ra2_i,
    output nf_cpu_pkg::word_t       rd1_o,
    output nf_cpu_pkg::word_t       rd2_o,
    input  logic                    wb_we_i,            // writeback from memory stage
    input  nf_cpu_pkg::reg_addr_t   wb_wa_i,
    input  nf_cpu_pkg::word_t       wb_wd_i
);

    nf_cpu_pkg::word_t  regs [1 : 31];                  // x1..x31, x0 not stored

    always_ff @(posedge clk) begin
        if (wb_we_i && (wb_wa_i != '0))
            regs[wb_wa_i] <= wb_wd_i;
    end

    // same-cycle write is seen by decode
    assign rd1_o = (ra1_i == '0)                  ? '0      :
                   (wb_we_i && wb_wa_i == ra1_i)  ? wb_wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0)                  ? '0      :
                   (wb_we_i && wb_wa_i == ra2_i)  ? wb_wd_i : regs[ra2_i];

endmodule : nf_reg_file

`default_nettype wire

//--- design/nf_exec_unit.sv
// operand forwarding, the ALU and the execute-to-memory register
`timescale 1ns/1ps
`default_nettype none

module nf_exec_unit (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            stall_i,
    nf_decode_exec_if.exec  de,
    nf_exec_mem_if.exec     em                          // also read back for forwarding
);

    logic               mem_writes;                     // memory stage holds a live register write
    logic               fwd1;
    logic               fwd2;
    nf_cpu_pkg::word_t  op_a;
    nf_cpu_pkg::word_t  rs2_val;                        // forwarded rs2, also store data
    nf_cpu_pkg::word_t  op_b;
    nf_cpu_pkg::word_t  result;

    assign mem_writes = em.valid & em.we_rf & (em.wa != '0);
    assign fwd1       = mem_writes & (em.wa == de.ra1);
    assign fwd2       = mem_writes & (em.wa == de.ra2);
    assign op_a       = fwd1 ? em.result : de.rd1;
    assign rs2_val    = fwd2 ? em.result : de.rd2;
    assign op_b       = de.srcb_imm ? de.imm : rs2_val;

    always_comb begin
        case (de.alu_op)
            nf_cpu_pkg::ALU_ADD:    result = op_a + op_b;
            nf_cpu_pkg::ALU_SUB:    result = op_a - op_b;
            nf_cpu_pkg::ALU_AND:    result = op_a & op_b;
            nf_cpu_pkg::ALU_OR:     result = op_a | op_b;
            nf_cpu_pkg::ALU_XOR:    result = op_a ^ op_b;
            nf_cpu_pkg::ALU_SLL:    result = op_a << op_b[4 : 0];   // shamt is low 5 bits
            nf_cpu_pkg::ALU_SRL:    result = op_a >> op_b[4 : 0];
            default:                result = op_b;                  // pass b for lui
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            em.valid <= 1'b0;
        else if (!stall_i)
            em.valid <= de.valid;
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            em.result     <= result;
            em.store_data <= rs2_val;
            em.wa         <= de.wa;
            em.we_rf      <= de.we_rf;
            em.is_store   <= de.is_store;
        end
    end

endmodule : nf_exec_unit

`default_nettype wire

//--- design/nf_store_unit.sv
// word store request, pipeline stall and register writeback
`timescale 1ns/1ps
`default_nettype none

module nf_store_unit (
    nf_exec_mem_if.mem              em,
    output nf_cpu_pkg::word_t       dmem_addr_o,
    output nf_cpu_pkg::word_t       dmem_wd_o,
    output logic                    dmem_req_o,
    input  logic                    dmem_ack_i,
    output logic                    stall_o,            // freezes fetch, decode, execute
    output logic                    wb_we_o,
    output nf_cpu_pkg::reg_addr_t   wb_wa_o,
    output nf_cpu_pkg::word_t       wb_wd_o
);

    // request stays up with stable address and data until ack
    assign dmem_req_o  = em.valid & em.is_store;
    assign dmem_addr_o = em.result;
    assign dmem_wd_o   = em.store_data;
    assign stall_o     = dmem_req_o & ~dmem_ack_i;

    // alu results commit at the end of this stage
    assign wb_we_o = em.valid & em.we_rf & ~em.is_store & (em.wa != '0);
    assign wb_wa_o = em.wa;
    assign wb_wd_o = em.result;

endmodule : nf_store_unit

`default_nettype wire

//--- design/nf_cpu.sv
// four-stage RV32I core top, fetch, decode, execute and memory/writeback
`timescale 1ns/1ps
`default_nettype none

module nf_cpu #(
    parameter nf_cpu_pkg::word_t RESET_PC = '0          // first fetch address
)(
    input  logic            clk,
    input  logic            rst_n_i,
    // instruction port
    output logic [31 : 0]   imem_addr_o,
    input  logic [31 : 0]   imem_rd_i,
    output logic            imem_req_o,
    input  logic            imem_ack_i,
    // data port, writes only
    output logic [31 : 0]   dmem_addr_o,
    output logic [31 : 0]   dmem_wd_o,
    output logic            dmem_req_o,
    input  logic            dmem_ack_i
);

    nf_cpu_pkg::word_t      instr;                      // fetch to decode
    logic                   instr_valid;
    nf_cpu_pkg::reg_addr_t  ra1;                        // decode reads
    nf_cpu_pkg::reg_addr_t  ra2;
    nf_cpu_pkg::word_t      rd1;
    nf_cpu_pkg::word_t      rd2;
    logic                   wb_we;                      // writeback bus
    nf_cpu_pkg::reg_addr_t  wb_wa;
    nf_cpu_pkg::word_t      wb_wd;
    logic                   stall;                      // store waiting for ack

    nf_decode_exec_if   de_if ();
    nf_exec_mem_if      em_if ();

    nf_fetch_unit #(
        .RESET_PC       ( RESET_PC      )
    ) nf_fetch_unit_0 (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .stall_i        ( stall         ),
        .imem_addr_o    ( imem_addr_o   ),
        .imem_rd_i      ( imem_rd_i     ),
        .imem_req_o     ( imem_req_o    ),
        .imem_ack_i     ( imem_ack_i    ),
        .instr_o        ( instr         ),
        .instr_valid_o  ( instr_valid   )
    );

    nf_decode_unit nf_decode_unit_0 (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .stall_i        ( stall         ),
        .instr_i        ( instr         ),
        .instr_valid_i  ( instr_valid   ),
        .ra1_o          ( ra1           ),
        .ra2_o          ( ra2           ),
        .rd1_i          ( rd1           ),
        .rd2_i          ( rd2           ),
        .de             ( de_if.decode  )
    );

    nf_reg_file nf_reg_file_0 (
        .clk            ( clk           ),
        .ra1_i          ( ra1           ),
        .ra2_i          ( ra2           ),
        .rd1_o          ( rd1           ),
        .rd2_o          ( rd2           ),
        .wb_we_i        ( wb_we         ),
        .wb_wa_i        ( wb_wa         ),
        .wb_wd_i        ( wb_wd         )
    );

    nf_exec_unit nf_exec_unit_0 (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .stall_i        ( stall         ),
        .de             ( de_if.exec    ),
        .em             ( em_if.exec    )
    );

    nf_store_unit nf_store_unit_0 (
        .em             ( em_if.mem     ),
        .dmem_addr_o    ( dmem_addr_o   ),
        .dmem_wd_o      ( dmem_wd_o     ),
        .dmem_req_o     ( dmem_req_o    ),
        .dmem_ack_i     ( dmem_ack_i    ),
        .stall_o        ( stall         ),
        .wb_we_o        ( wb_we         ),
        .wb_wa_o        ( wb_wa         ),
        .wb_wd_o        ( wb_wd         )
    );

endmodule : nf_cpu

`default_nettype wire

//--- tests/nf_cpu_tests.svh
// rv32i instruction encoders, immediate sign extension and the directed test tasks
// reset, immediates with stores, register chain, instruction and data back-pressure

    function automatic nf_cpu_pkg::word_t sext12(input logic [11 : 0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic nf_cpu_pkg::word_t r_type(input logic [6 : 0] f7, input logic [2 : 0] f3,
            input logic [4 : 0] rd, input logic [4 : 0] rs1, input logic [4 : 0] rs2);
        return {f7, rs2, rs1, f3, rd, nf_cpu_pkg::OPC_OP};
    endfunction

    function automatic nf_cpu_pkg::word_t i_type(input logic [2 : 0] f3, input logic [4 : 0] rd,
            input logic [4 : 0] rs1, input logic [11 : 0] imm);
        return {imm, rs1, f3, rd, nf_cpu_pkg::OPC_OP_IMM};
    endfunction

    // sw rs2, off(rs1)
    function automatic nf_cpu_pkg::word_t s_type(input logic [4 : 0] rs2, input logic [4 : 0] rs1,
            input logic [11 : 0] off);
        return {off[11 : 5], rs2, rs1, nf_cpu_pkg::F3_SW, off[4 : 0], nf_cpu_pkg::OPC_STORE};
    endfunction

    function automatic nf_cpu_pkg::word_t u_type(input logic [4 : 0] rd, input logic [19 : 0] imm);
        return {imm, rd, nf_cpu_pkg::OPC_LUI};
    endfunction

    task automatic expect_store(input nf_cpu_pkg::word_t addr, input nf_cpu_pkg::word_t data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic setup_test(input logic iack_r, input logic dack_r, input int delay);
        iack_rand  = iack_r;
        dack_rand  = dack_r;
        dack_delay = delay;
        prog_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    // reset, wait for all stores, let the pipe drain, then compare
    task automatic run_program(input string name);
        int err_start;
        err_start = errors;
        apply_reset();
        while (store_addr_q.size() < exp_addr_q.size())
            @(negedge clk);
        repeat (12) @(negedge clk);                             // catches extra stores
        compare_stores();
        report_test(name, err_start);
    endtask

    task automatic reset_test();
        int err_start;
        err_start = errors;
        setup_test(1'b0, 1'b0, 0);                              // nop stream only
        apply_reset();
        @(negedge clk);
        check_bit("imem_req_o", imem_req_o, 1'b1);              // first cycle after release
        check_word("imem_addr_o", imem_addr_o, RESET_PC);
        repeat (6) @(negedge clk);
        check_word("imem_addr_o", imem_addr_o, RESET_PC + 32'd24);
        check_bit("dmem_req_o", dmem_req_o, 1'b0);
        report_test("reset and fetch", err_start);
    endtask

    task automatic imm_store_test();
        nf_cpu_pkg::word_t base, lui_v, addi_v, ori_v, xori_v, andi_v;
        base   = sext12(12'h400);
        lui_v  = {20'h12345, 12'h000};
        addi_v = sext12(12'hffb);                               // -5
        ori_v  = lui_v | sext12(12'h5a5);
        xori_v = addi_v ^ sext12(12'h7ff);
        andi_v = ori_v & sext12(12'hf00);
        setup_test(1'b0, 1'b0, 1);
        prog_q.push_back(i_type(nf_cpu_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'h400));
        prog_q.push_back(u_type(5'd2, 20'h12345));
        prog_q.push_back(i_type(nf_cpu_pkg::F3_ADD_SUB, 5'd3, 5'd0, 12'hffb));
        prog_q.push_back(i_type(nf_cpu_pkg::F3_OR, 5'd4, 5'd2, 12'h5a5));
        prog_q.push_back(i_type(nf_cpu_pkg::F3_XOR, 5'd5, 5'd3, 12'h7ff));
        prog_q.push_back(i_type(nf_cpu_pkg::F3_AND, 5'd6, 5'd4, 12'hf00));  // x4 forwarded
        prog_q.push_back(s_type(5'd2, 5'd1, 12'h000));
        prog_q.push_back(s_type(5'd3, 5'd1, 12'h004));
        prog_q.push_back(s_type(5'd4, 5'd1, 12'h008));
        prog_q.push_back(s_type(5'd5, 5'd1, 12'hffc));          // negative offset
        prog_q.push_back(s_type(5'd6, 5'd1, 12'h010));
        expect_store(base, lui_v);
        expect_store(base + 32'd4, addi_v);
        expect_store(base + 32'd8, ori_v);
        expect_store(base + sext12(12'hffc), xori_v);
        expect_store(base + 32'd16, andi_v);
        run_program("immediates and stores");
    endtask

    // each op consumes the result just before it
    task automatic chain_test(input string name, input logic iack_r);
        nf_cpu_pkg::word_t r [1 : 9];
        int i;
        r[1] = sext12(12'h035);
        r[2] = r[1] + sext12(12'hfce);
        r[3] = r[1] + r[2];
        r[4] = r[2] - r[3];
        r[5] = r[4] & r[1];
        r[6] = r[2] | r[5];
        r[7] = r[6] ^ r[4];
        r[8] = r[1] << r[7][4 : 0];
        r[9] = r[8] >> r[2][4 : 0];
        setup_test(iack_r, 1'b0, 0);
        prog_q.push_back(i_type(nf_cpu_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'h035));
        prog_q.push_back(i_type(nf_cpu_pkg::F3_ADD_SUB, 5'd2, 5'd1, 12'hfce));
        prog_q.push_back(r_type(7'd0, nf_cpu_pkg::F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
        prog_q.push_back(r_type(nf_cpu_pkg::F7_SUB, nf_cpu_pkg::F3_ADD_SUB, 5'd4, 5'd2, 5'd3));
        prog_q.push_back(r_type(7'd0, nf_cpu_pkg::F3_AND, 5'd5, 5'd4, 5'd1));
        prog_q.push_back(r_type(7'd0, nf_cpu_pkg::F3_OR, 5'd6, 5'd2, 5'd5));
        prog_q.push_back(r_type(7'd0, nf_cpu_pkg::F3_XOR, 5'd7, 5'd6, 5'd4));
        prog_q.push_back(r_type(7'd0, nf_cpu_pkg::F3_SLL, 5'd8, 5'd1, 5'd7));
        prog_q.push_back(r_type(7'd0, nf_cpu_pkg::F3_SRL, 5'd9, 5'd8, 5'd2));
        prog_q.push_back(s_type(5'd9, 5'd0, 12'h120));          // store data forwarded
        expect_store(sext12(12'h120), r[9]);
        for (i = 3; i <= 8; i++) begin
            prog_q.push_back(s_type(5'(i), 5'd0, 12'h100 + 12'(4 * (i - 3))));
            expect_store(sext12(12'h100) + 32'(4 * (i - 3)), r[i]);
        end
        run_program(name);
    endtask

    task automatic dmem_x0_test();
        nf_cpu_pkg::word_t v10, v11;
        v10 = sext12(12'h077);
        v11 = v10 + sext12(12'h001);
        setup_test(1'b0, 1'b1, 0);
        prog_q.push_back(i_type(nf_cpu_pkg::F3_ADD_SUB, 5'd10, 5'd0, 12'h077));
        prog_q.push_back(i_type(nf_cpu_pkg::F3_ADD_SUB, 5'd0, 5'd0, 12'h055));  // write to x0
        prog_q.push_back(s_type(5'd0, 5'd0, 12'h200));
        prog_q.push_back(s_type(5'd10, 5'd0, 12'h204));
        prog_q.push_back(i_type(nf_cpu_pkg::F3_ADD_SUB, 5'd11, 5'd10, 12'h001));
        prog_q.push_back(s_type(5'd11, 5'd0, 12'h208));
        prog_q.push_back(s_type(5'd11, 5'd0, 12'h20c));
        expect_store(sext12(12'h200), 32'd0);                   // x0 always reads zero
        expect_store(sext12(12'h204), v10);
        expect_store(sext12(12'h208), v11);
        expect_store(sext12(12'h20c), v11);
        run_program("data back-pressure and x0");
    endtask

//--- tests/nf_cpu_tb.sv
// testbench top for the four-stage core, clock, reset, instruction and data memory models
// compare tasks, fetch address monitor and the run timeout
`timescale 1ns/1ps
`default_nettype none

module nf_cpu_tb;

    localparam nf_cpu_pkg::word_t RESET_PC = 32'h0000_0000;
    localparam nf_cpu_pkg::word_t NOP_WORD = 32'h0000_0013;     // addi x0, x0, 0
    localparam int PROG_WORDS     = 11 + 16 + 16 + 7;           // program words of tests 2 to 5
    localparam int TIMEOUT_CYCLES = PROG_WORDS * 8 + 200;       // worst ack delay plus margin

    logic               clk = 1'b0;
    logic               rst_n_i;
    logic [31 : 0]      imem_addr_o;
    logic [31 : 0]      imem_rd_i;
    logic               imem_req_o;
    logic               imem_ack_i;
    logic [31 : 0]      dmem_addr_o;
    logic [31 : 0]      dmem_wd_o;
    logic               dmem_req_o;
    logic               dmem_ack_i;

    nf_cpu_pkg::word_t  prog_q [$];                             // one word per address / 4
    nf_cpu_pkg::word_t  store_addr_q [$];                       // stores seen on the data port
    nf_cpu_pkg::word_t  store_data_q [$];
    nf_cpu_pkg::word_t  exp_addr_q [$];                         // stores the program must make
    nf_cpu_pkg::word_t  exp_data_q [$];
    nf_cpu_pkg::word_t  exp_pc;                                 // next fetch address
    nf_cpu_pkg::word_t  held_addr;                              // request under wait
    nf_cpu_pkg::word_t  held_data;
    logic               iack_rand;                              // random instruction ack
    logic               dack_rand;                              // random 1 to 5 cycle data ack
    int                 dack_delay;                             // fixed data ack delay otherwise
    int                 wait_cnt = 0;
    int                 ack_delay = 0;
    int                 cycles = 0;
    int                 errors = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    integer             seed = 72887;

    nf_cpu #(
        .RESET_PC       ( RESET_PC      )
    ) nf_cpu_i (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .imem_addr_o    ( imem_addr_o   ),
        .imem_rd_i      ( imem_rd_i     ),
        .imem_req_o     ( imem_req_o    ),
        .imem_ack_i     ( imem_ack_i    ),
        .dmem_addr_o    ( dmem_addr_o   ),
        .dmem_wd_o      ( dmem_wd_o     ),
        .dmem_req_o     ( dmem_req_o    ),
        .dmem_ack_i     ( dmem_ack_i    )
    );

    always #50 clk = ~clk;                                      // 100 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, expected stores never completed", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // reference pc, moves by 4 on each accepted request
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            exp_pc <= RESET_PC;
        else if (imem_req_o && imem_ack_i)
            exp_pc <= exp_pc + 32'd4;
    end

    // instruction memory, data returned in the ack cycle
    always @(negedge clk) begin
        if (rst_n_i)
            check_word("imem_addr_o", imem_addr_o, exp_pc);
        if (iack_rand)
            imem_ack_i <= ($random(seed) & 1) != 0;
        else
            imem_ack_i <= 1'b1;
        imem_rd_i <= fetch_word(imem_addr_o);
    end

    // data memory, acks after a delay and logs each completed store
    always @(negedge clk) begin
        if (!rst_n_i || !dmem_req_o) begin
            dmem_ack_i <= 1'b0;
            wait_cnt = 0;
        end else begin
            if (wait_cnt == 0) begin                            // new request
                held_addr = dmem_addr_o;
                held_data = dmem_wd_o;
                ack_delay = dack_rand ? 1 + int'($unsigned($random(seed)) % 5) : dack_delay;
            end else begin                                      // waiting, request must hold
                check_word("dmem_addr_o", dmem_addr_o, held_addr);
                check_word("dmem_wd_o", dmem_wd_o, held_data);
            end
            if (wait_cnt >= ack_delay) begin
                dmem_ack_i <= 1'b1;                             // store completes at next edge
                store_addr_q.push_back(dmem_addr_o);
                store_data_q.push_back(dmem_wd_o);
                wait_cnt = 0;
            end else begin
                dmem_ack_i <= 1'b0;
                wait_cnt = wait_cnt + 1;
            end
        end
    end

    function automatic nf_cpu_pkg::word_t fetch_word(input nf_cpu_pkg::word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog_q.size())
            return prog_q[idx];
        return NOP_WORD;                                        // past the end of the program
    endfunction

    task automatic check_word(input string name, input nf_cpu_pkg::word_t act,
                              input nf_cpu_pkg::word_t exp);
        if (act !== exp) begin
            errors = errors + 1;
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            errors = errors + 1;
            $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, act, exp);
        end
    endtask

    // 10 cycles of reset, both requests must stay low
    task automatic apply_reset();
        @(negedge clk);
        rst_n_i <= 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_bit("imem_req_o", imem_req_o, 1'b0);
            check_bit("dmem_req_o", dmem_req_o, 1'b0);
        end
        store_addr_q.delete();
        store_data_q.delete();
        rst_n_i <= 1'b1;
    endtask

    task automatic compare_stores();
        if (store_addr_q.size() != exp_addr_q.size()) begin
            errors = errors + 1;
            $display("store count wrong at t=%0t: %0d stores seen, %0d expected",
                     $time, store_addr_q.size(), exp_addr_q.size());
        end else begin
            foreach (exp_addr_q[i]) begin
                check_word("dmem_addr_o", store_addr_q[i], exp_addr_q[i]);
                check_word("dmem_wd_o", store_data_q[i], exp_data_q[i]);
            end
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run = tests_run + 1;
        if (errors == err_start) begin
            $display("[ok]   %s", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("[fail] %s, %0d errors", name, errors - err_start);
        end
    endtask

    `include "nf_cpu_tests.svh"

    initial begin
        rst_n_i    = 1'b0;
        imem_rd_i  = NOP_WORD;
        imem_ack_i = 1'b0;
        dmem_ack_i = 1'b0;
        iack_rand  = 1'b0;
        dack_rand  = 1'b0;
        dack_delay = 0;
        reset_test();
        imm_store_test();
        chain_test("register ops and forwarding", 1'b0);
        chain_test("instruction back-pressure", 1'b1);
        dmem_x0_test();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule : nf_cpu_tb

`default_nettype wire

//--- vlog.f
+incdir+tests
design/nf_cpu_pkg.sv
design/nf_stage_ifs.sv
design/nf_fetch_unit.sv
design/nf_decode_unit.sv
design/nf_reg_file.sv
design/nf_exec_unit.sv
design/nf_store_unit.sv
design/nf_cpu.sv
tests/nf_cpu_tb.sv
